//--- cpu6502.f
+incdir+hdl
hdl/cpu6502Pkg.sv
hdl/opcodeDecoder.sv
hdl/aluExecute.sv
hdl/registerWriteback.sv
hdl/cpu6502Core.sv
sim/cpu6502_assert.sv
sim/cpu6502Tb.sv

//--- run.sh
#!/bin/sh
# compile and run the cpu6502 testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

rm -rf obj_dir

verilator --binary --timing --assert -j 0 \
    -f cpu6502.f --top-module cpu6502Tb -o cpu6502Sim
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/cpu6502Sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q -F '*** FAILED ***' "$LOG"; then
    exit 1
fi
exit 0

//--- sim/cpu6502Tb.sv
`timescale 1ns/1ps

`include "cpu6502_config.svh"

module cpu6502Tb;

    import cpu6502Pkg::*;

    localparam int clkPeriod = 4;
    localparam int resetCycles = 10;
    localparam int numInstr = 20 + 36 + 60 + 200 + 9; // summed per test in run order
    localparam int watchdogNs = (numInstr + resetCycles) * clkPeriod * 4;
    localparam regFile_t resetRegs = '{a: 8'h00, x: 8'h00, y: 8'h00,
                                       s: `SP_RESET, p: `P_RESET};

    // expected state after one retire
    typedef struct packed {
        regFile_t regs;
        logic     unsupported;
    } expect_t;

    logic        clk;
    logic        reset;
    logic        instrValid;
    opcodeWord_t opcode;
    logic [7:0]  operand;
    regFile_t    regs;
    logic        retire;
    logic        unsupported;

    regFile_t    modelRegs;
    expect_t     expectQ[$];
    expect_t     head;
    logic [7:0]  supportedOps[$];
    cmd_t        supportedCmds[$];
    logic [7:0]  otherOps[$];
    cmd_t        otherCmds[$];
    integer      seed;
    int          errors;
    int          issued;

    cpu6502Core cpu6502Core_i (
        .clk         (clk),
        .reset       (reset),
        .instrValid  (instrValid),
        .opcode      (opcode),
        .operand     (operand),
        .regs        (regs),
        .retire      (retire),
        .unsupported (unsupported)
    );

    bind cpu6502Core cpu6502Assert cpu6502Assert_i (
        .clk         (clk),
        .reset       (reset),
        .instrValid  (instrValid),
        .retire      (retire),
        .unsupported (unsupported),
        .regs        (regs)
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    initial begin
        #(watchdogNs);
        $display("watchdog expired, the tests did not finish in time");
        $display("*** FAILED ***");
        $finish;
    end

    // maps an opcode byte to its mnemonic and raises ok only for the executed subset
    function automatic cmd_t cmdOf(input logic [7:0] op, output logic ok);
        ok = 1'b0;
        for (int k = 0; k < otherOps.size(); k++)
            if (otherOps[k] == op)
                return otherCmds[k];
        ok = 1'b1;
        for (int k = 0; k < supportedOps.size(); k++)
            if (supportedOps[k] == op)
                return supportedCmds[k];
        ok = 1'b0;
        return NOP;
    endfunction

    // applies the 6502 rules for one instruction in binary arithmetic
    function automatic regFile_t stepModel(input regFile_t r, input cmd_t cmd,
                                           input logic [7:0] v);
        regFile_t   n;
        int         ua;
        int         uv;
        int         sa;
        int         sv;
        int         c;
        int         sum;
        int         ssum;
        logic [7:0] res;
        n    = r;
        ua   = int'(r.a);
        uv   = int'(v);
        sa   = int'($signed(r.a));
        sv   = int'($signed(v));
        c    = int'(r.p[0]);
        res  = 8'h00;
        case (cmd)
            LDA: n.a = v;
            LDX: n.x = v;
            LDY: n.y = v;
            TAX: n.x = r.a;
            TAY: n.y = r.a;
            TXA: n.a = r.x;
            TYA: n.a = r.y;
            TSX: n.x = r.s;
            TXS: n.s = r.x;
            INX: n.x = r.x + 8'd1;
            DEX: n.x = r.x - 8'd1;
            INY: n.y = r.y + 8'd1;
            DEY: n.y = r.y - 8'd1;
            AND: n.a = r.a & v;
            ORA: n.a = r.a | v;
            EOR: n.a = r.a ^ v;
            ADC: begin
                sum    = ua + uv + c;
                ssum   = sa + sv + c;
                n.a    = sum[7:0];
                n.p[0] = sum > 255;
                n.p[6] = (ssum > 127) || (ssum < -128);
            end
            SBC: begin
                sum    = ua - uv - (1 - c); // borrow is inverted carry
                ssum   = sa - sv - (1 - c);
                n.a    = sum[7:0];
                n.p[0] = sum >= 0;
                n.p[6] = (ssum > 127) || (ssum < -128);
            end
            CMP, CPX, CPY: begin
                res    = (cmd == CPX) ? r.x : (cmd == CPY) ? r.y : r.a;
                n.p[0] = res >= v;
                res    = res - v;
            end
            ASLA: begin
                n.p[0] = r.a[7];
                n.a    = {r.a[6:0], 1'b0};
            end
            ROLA: begin
                n.p[0] = r.a[7];
                n.a    = {r.a[6:0], r.p[0]};
            end
            LSRA: begin
                n.p[0] = r.a[0];
                n.a    = {1'b0, r.a[7:1]};
            end
            RORA: begin
                n.p[0] = r.a[0];
                n.a    = {r.p[0], r.a[7:1]};
            end
            CLC: n.p[0] = 1'b0;
            SEC: n.p[0] = 1'b1;
            CLI: n.p[2] = 1'b0;
            SEI: n.p[2] = 1'b1;
            CLD: n.p[3] = 1'b0;
            SED: n.p[3] = 1'b1;
            CLV: n.p[6] = 1'b0;
            default: ; // NOP
        endcase
        if (cmd inside {LDX, TAX, TSX, INX, DEX})
            res = n.x;
        else if (cmd inside {LDY, TAY, INY, DEY})
            res = n.y;
        else if (!(cmd inside {CMP, CPX, CPY}))
            res = n.a;
        if (!(cmd inside {TXS, NOP, CLC, SEC, CLI, SEI, CLV, CLD, SED})) begin
            n.p[7] = res[7];
            n.p[1] = (res == 8'h00);
        end
        return n;
    endfunction

    task automatic checkRegs(input regFile_t got, input regFile_t want);
        if (got !== want) begin
            errors++;
            $display("ERR %0t: regs a,x,y,s,p = %h %h %h %h %h, expected %h %h %h %h %h",
                     $time, got.a, got.x, got.y, got.s, got.p,
                     want.a, want.x, want.y, want.s, want.p);
        end
    endtask

    task automatic checkUnsupported(input logic got, input logic want);
        if (got !== want) begin
            errors++;
            $display("ERR %0t: unsupported is %b, expected %b", $time, got, want);
        end
    endtask

    task automatic checkCmd(input cmd_t got, input cmd_t want, input logic [7:0] op);
        if (got !== want) begin
            errors++;
            $display("ERR %0t: opcode %h decoded as %s, expected %s",
                     $time, op, got.name(), want.name());
        end
    endtask

    // drives one instruction for one cycle and queues what it should retire with
    task automatic issue(input logic [7:0] op, input logic [7:0] opnd);
        cmd_t    cmd;
        logic    ok;
        expect_t e;
        cmd = cmdOf(op, ok);
        if (ok)
            modelRegs = stepModel(modelRegs, cmd, opnd);
        e.regs        = modelRegs;
        e.unsupported = !ok;
        expectQ.push_back(e);
        instrValid  = 1'b1;
        opcode.raw  = op;
        operand     = opnd;
        issued++;
        @(posedge clk);
        #1;
        instrValid = 1'b0;
        checkCmd(cpu6502Core_i.decoded.cmd, cmd, op); // decoder stage holds it now
    endtask

    task automatic waitRetired();
        int cycles;
        cycles = 0;
        while (expectQ.size() != 0 && cycles < 10) begin
            @(posedge clk);
            cycles++;
        end
        if (expectQ.size() != 0) begin
            errors++;
            $display("retire never came for %0d issued instruction(s)", expectQ.size());
            expectQ.delete();
        end
        @(posedge clk);
        #1;
    endtask

    // each retire is matched against the oldest queued expectation
    initial begin
        forever begin
            @(negedge clk);
            if (!reset && retire === 1'b1) begin
                if (expectQ.size() == 0) begin
                    errors++;
                    $display("retire pulsed at %0t with no instruction outstanding", $time);
                end else begin
                    head = expectQ.pop_front();
                    checkRegs(regs, head.regs);
                    checkUnsupported(unsupported, head.unsupported);
                end
            end
        end
    end

    task automatic resetState();
        checkRegs(regs, resetRegs);
        checkUnsupported(unsupported, 1'b0);
        repeat (5) begin
            @(posedge clk);
            #1;
            if (retire !== 1'b0) begin
                errors++;
                $display("retire went high at %0t while nothing was issued", $time);
            end
        end
    endtask

    task automatic loadsAndTransfers();
        logic [7:0] v;
        for (int i = 0; i < 3; i++) begin
            v = (i == 0) ? 8'h00 : (i == 1) ? 8'h80 : 8'h7F;
            issue(8'hA9, v);
            issue(8'hA2, v);
            issue(8'hA0, v);
        end
        issue(8'hA9, 8'hC3);
        issue(8'hAA, 8'h00);
        issue(8'hA9, 8'h3C); // X and Y end up different
        issue(8'hA8, 8'h00);
        issue(8'h8A, 8'h00);
        issue(8'h98, 8'h00);
        issue(8'hBA, 8'h00);
        issue(8'hA2, 8'h00);
        issue(8'hA9, 8'h80); // N set and Z clear before TXS
        issue(8'h9A, 8'h00);
        issue(8'hBA, 8'h00);
        waitRetired();
    endtask

    task automatic arithCase(input logic [7:0] op, input logic [7:0] a,
                             input logic [7:0] b, input logic cin);
        issue(cin ? 8'h38 : 8'h18, 8'h00);
        issue(8'hA9, a);
        issue(op, b);
    endtask

    task automatic adderCases();
        arithCase(8'h69, 8'h50, 8'h10, 1'b0);
        arithCase(8'h69, 8'h50, 8'h50, 1'b0); // positive overflow
        arithCase(8'h69, 8'hD0, 8'h90, 1'b0); // negative overflow with carry
        arithCase(8'h69, 8'hFF, 8'h01, 1'b0);
        arithCase(8'h69, 8'hFF, 8'h00, 1'b1);
        arithCase(8'h69, 8'h7F, 8'h00, 1'b1);
        arithCase(8'hE9, 8'h50, 8'hF0, 1'b1);
        arithCase(8'hE9, 8'h50, 8'hB0, 1'b1);
        arithCase(8'hE9, 8'hD0, 8'h70, 1'b1);
        arithCase(8'hE9, 8'h00, 8'h01, 1'b1); // borrow out
        arithCase(8'hE9, 8'h05, 8'h05, 1'b0); // borrow in
        arithCase(8'hE9, 8'h80, 8'h01, 1'b1);
        waitRetired();
    endtask

    task automatic logicShiftsFlags();
        logic [7:0] shiftOp;
        issue(8'hA9, 8'hF0);
        issue(8'h29, 8'h3C);
        issue(8'h09, 8'h81);
        issue(8'h49, 8'hFF);
        issue(8'h29, 8'h00);
        issue(8'hA9, 8'h40);
        issue(8'hC9, 8'h30);
        issue(8'hC9, 8'h40);
        issue(8'hC9, 8'h50);
        issue(8'hA2, 8'h10);
        issue(8'hE0, 8'h20);
        issue(8'hE0, 8'h10);
        issue(8'hE0, 8'h05);
        issue(8'hA0, 8'h80);
        issue(8'hC0, 8'h7F);
        issue(8'hC0, 8'h80);
        issue(8'hC0, 8'h81);
        for (int cin = 0; cin < 2; cin++) begin
            for (int k = 0; k < 4; k++) begin
                shiftOp = (k == 0) ? 8'h0A : (k == 1) ? 8'h2A : (k == 2) ? 8'h4A : 8'h6A;
                issue((cin == 1) ? 8'h38 : 8'h18, 8'h00);
                issue(8'hA9, 8'h81); // both end bits set
                issue(shiftOp, 8'h00);
            end
        end
        issue(8'hA2, 8'hFF);
        issue(8'hE8, 8'h00);
        issue(8'hCA, 8'h00);
        issue(8'hCA, 8'h00);
        issue(8'hA0, 8'h00);
        issue(8'h88, 8'h00);
        issue(8'hC8, 8'h00);
        issue(8'hC8, 8'h00);
        issue(8'h18, 8'h00); // C and I start set here
        issue(8'h38, 8'h00);
        issue(8'h58, 8'h00);
        issue(8'h78, 8'h00);
        issue(8'hF8, 8'h00);
        issue(8'hD8, 8'h00);
        issue(8'h18, 8'h00);
        issue(8'hA9, 8'h50);
        issue(8'h69, 8'h50); // sets V for CLV
        issue(8'hB8, 8'h00);
        issue(8'hEA, 8'h00);
        waitRetired();
    endtask

    task automatic randomStream();
        logic [31:0] rnd;
        int          idx;
        for (int i = 0; i < 200; i++) begin
            rnd = $random(seed);
            idx = int'(rnd[15:8]) % supportedOps.size();
            issue(supportedOps[idx], rnd[7:0]);
        end
        waitRetired();
    endtask

    task automatic unsupportedMix();
        issue(8'hA9, 8'h11);
        issue(8'hA5, 8'h22); // LDA zpg
        issue(8'hA2, 8'h33);
        issue(8'h4C, 8'h44);
        issue(8'h00, 8'h00);
        issue(8'hE8, 8'h00);
        issue(8'hD0, 8'h10);
        issue(8'h48, 8'h00);
        issue(8'hA8, 8'h00);
        waitRetired();
    endtask

    initial begin
        seed   = 32'hd456043e;
        errors = 0;
        issued = 0;
        supportedOps  = '{8'hA9, 8'hA2, 8'hA0, 8'h69, 8'hE9, 8'h29, 8'h09, 8'h49, 8'hC9,
                          8'hE0, 8'hC0, 8'hAA, 8'hA8, 8'h8A, 8'h98, 8'hBA, 8'h9A, 8'hE8,
                          8'hC8, 8'hCA, 8'h88, 8'h18, 8'h38, 8'h58, 8'h78, 8'hB8, 8'hD8,
                          8'hF8, 8'h0A, 8'h2A, 8'h4A, 8'h6A, 8'hEA};
        supportedCmds = '{LDA, LDX, LDY, ADC, SBC, AND, ORA, EOR, CMP,
                          CPX, CPY, TAX, TAY, TXA, TYA, TSX, TXS, INX,
                          INY, DEX, DEY, CLC, SEC, CLI, SEI, CLV, CLD,
                          SED, ASLA, ROLA, LSRA, RORA, NOP};
        otherOps  = '{8'hA5, 8'h4C, 8'h00, 8'hD0, 8'h48};
        otherCmds = '{LDA, JMP, BRK, BNE, PHA};
        reset      = 1'b1;
        instrValid = 1'b0;
        opcode     = '0;
        operand    = 8'h00;
        modelRegs  = resetRegs;
        repeat (resetCycles) @(posedge clk);
        #1;
        reset = 1'b0;

        resetState();
        loadsAndTransfers();
        adderCases();
        logicShiftsFlags();
        randomStream();
        unsupportedMix();

        $display("errors: %0d, instructions issued: %0d", errors, issued);
        if (errors == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

//--- sim/cpu6502_assert.sv
`timescale 1ns/1ps

module cpu6502Assert (
    input logic                 clk,
    input logic                 reset,
    input logic                 instrValid,
    input logic                 retire,
    input logic                 unsupported,
    input cpu6502Pkg::regFile_t regs
);

    // fixed two-stage pipeline, no stalls
    latencyForward: assert property (@(posedge clk) disable iff (reset)
        instrValid |-> ##2 retire)
        else $error("instrValid was not followed by retire two cycles later");

    latencyBackward: assert property (@(posedge clk) disable iff (reset)
        retire |-> $past(instrValid, 2))
        else $error("retire without instrValid two cycles earlier");

    unsupportedWithRetire: assert property (@(posedge clk)
        unsupported |-> retire)
        else $error("unsupported high without retire");

    bit5High: assert property (@(posedge clk) disable iff (reset)
        regs.p[5])
        else $error("P bit 5 is not 1");

    quietAfterReset: assert property (@(posedge clk)
        reset |=> !retire)
        else $error("retire high in the cycle after reset");

endmodule

//--- hdl/cpu6502Core.sv
`timescale 1ns/1ps

module cpu6502Core (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    instrValid,
    input  cpu6502Pkg::opcodeWord_t opcode,
    input  logic [7:0]              operand,
    output cpu6502Pkg::regFile_t    regs,
    output logic                    retire,
    output logic                    unsupported
);

    import cpu6502Pkg::*;

    decodedOp_t  decoded;
    logic        decodedValid;
    execResult_t result;

    opcodeDecoder opcodeDecoder_i (
        .clk          (clk),
        .reset        (reset),
        .instrValid   (instrValid),
        .opcode       (opcode),
        .operand      (operand),
        .decoded      (decoded),
        .decodedValid (decodedValid)
    );

    // reads regs already holding the previous instruction, no forwarding
    aluExecute aluExecute_i (
        .decoded      (decoded),
        .decodedValid (decodedValid),
        .regs         (regs),
        .result       (result)
    );

    registerWriteback registerWriteback_i (
        .clk          (clk),
        .reset        (reset),
        .result       (result),
        .regs         (regs),
        .retire       (retire),
        .unsupported  (unsupported)
    );

endmodule

//--- hdl/registerWriteback.sv
`timescale 1ns/1ps

`include "cpu6502_config.svh"

module registerWriteback (
    input  logic                    clk,
    input  logic                    reset,
    input  cpu6502Pkg::execResult_t result,
    output cpu6502Pkg::regFile_t    regs,
    output logic                    retire,
    output logic                    unsupported
);

    import cpu6502Pkg::*;

    logic [7:0] writeMask;
    logic       commit;

    assign writeMask = result.flagMask & 8'hCF; // B and bit 5 are fixed
    assign commit    = result.valid && result.supported;

    always_ff @(posedge clk) begin
        if (reset) begin
            regs        <= '{a: 8'h00, x: 8'h00, y: 8'h00, s: `SP_RESET, p: `P_RESET};
            retire      <= 1'b0;
            unsupported <= 1'b0;
        end else begin
            retire      <= result.valid;
            unsupported <= result.valid && !result.supported;
            if (commit) begin
                case (result.dest)
                    regA: regs.a <= result.value;
                    regX: regs.x <= result.value;
                    regY: regs.y <= result.value;
                    regS: regs.s <= result.value;
                    default: ; // compares, flag ops, NOP
                endcase
                regs.p <= (regs.p & ~writeMask) | (result.flagValue & writeMask);
            end
        end
    end

endmodule

//--- hdl/aluExecute.sv
`timescale 1ns/1ps

module aluExecute (
    input  cpu6502Pkg::decodedOp_t  decoded,
    input  logic                    decodedValid,
    input  cpu6502Pkg::regFile_t    regs,
    output cpu6502Pkg::execResult_t result
);

    import cpu6502Pkg::*;

    // status bit positions
    localparam int flagC = 0;
    localparam int flagZ = 1;
    localparam int flagI = 2;
    localparam int flagD = 3;
    localparam int flagV = 6;
    localparam int flagN = 7;

    logic [7:0] addend;
    logic [8:0] sum;
    logic       overflow;
    logic [7:0] cmpReg;
    logic [8:0] cmpDiff;
    logic       modeOk;
    logic       kept;
    logic       setNZ;
    logic       setC;
    logic       setV;
    logic       carry;
    destReg_t   dest;
    logic [7:0] value;
    logic [7:0] mask;
    logic [7:0] fval;

    // D never reaches the adder
    assign addend   = (decoded.cmd == SBC) ? ~decoded.operand : decoded.operand;
    assign sum      = {1'b0, regs.a} + {1'b0, addend} + {8'b0, regs.p[flagC]};
    assign overflow = (regs.a[7] == addend[7]) && (sum[7] != regs.a[7]);

    always_comb begin
        case (decoded.cmd)
            CPX: cmpReg = regs.x;
            CPY: cmpReg = regs.y;
            default: cmpReg = regs.a;
        endcase
    end

    assign cmpDiff = {1'b0, cmpReg} + {1'b0, ~decoded.operand} + 9'd1; // carry out means no borrow
    assign modeOk  = decoded.mode inside {impl, accum, immediate};

    always_comb begin
        kept  = 1'b1;
        setNZ = 1'b0;
        setC  = 1'b0;
        setV  = 1'b0;
        carry = 1'b0;
        dest  = none;
        value = 8'h00;
        mask  = 8'h00;

        case (decoded.cmd)
            TAX, TAY, TSX: begin
                dest  = (decoded.cmd == TAY) ? regY : regX;
                value = (decoded.cmd == TSX) ? regs.s : regs.a;
                setNZ = 1'b1;
            end
            TXA, TYA: begin
                dest  = regA;
                value = (decoded.cmd == TXA) ? regs.x : regs.y;
                setNZ = 1'b1;
            end
            TXS: begin
                dest  = regS; // no flags
                value = regs.x;
            end
            INX, DEX: begin
                dest  = regX;
                value = (decoded.cmd == INX) ? regs.x + 8'd1 : regs.x - 8'd1;
                setNZ = 1'b1;
            end
            INY, DEY: begin
                dest  = regY;
                value = (decoded.cmd == INY) ? regs.y + 8'd1 : regs.y - 8'd1;
                setNZ = 1'b1;
            end
            CLC, SEC: mask[flagC] = 1'b1;
            CLI, SEI: mask[flagI] = 1'b1;
            CLD, SED: mask[flagD] = 1'b1;
            CLV: mask[flagV] = 1'b1;
            ASLA, ROLA: begin
                dest         = regA;
                {carry, value} = {regs.a, (decoded.cmd == ROLA) & regs.p[flagC]};
                setNZ        = 1'b1;
                setC         = 1'b1;
            end
            LSRA, RORA: begin
                dest         = regA;
                {value, carry} = {(decoded.cmd == RORA) & regs.p[flagC], regs.a};
                setNZ        = 1'b1;
                setC         = 1'b1;
            end
            LDA, LDX, LDY: begin
                dest  = (decoded.cmd == LDA) ? regA : (decoded.cmd == LDX) ? regX : regY;
                value = decoded.operand;
                setNZ = 1'b1;
            end
            ADC, SBC: begin
                dest  = regA;
                value = sum[7:0];
                carry = sum[8];
                setNZ = 1'b1;
                setC  = 1'b1;
                setV  = 1'b1;
            end
            AND, ORA, EOR: begin
                dest  = regA;
                value = (decoded.cmd == AND) ? regs.a & decoded.operand :
                        (decoded.cmd == ORA) ? regs.a | decoded.operand :
                                               regs.a ^ decoded.operand;
                setNZ = 1'b1;
            end
            CMP, CPX, CPY: begin
                value = cmpDiff[7:0]; // compares leave dest at none
                carry = cmpDiff[8];
                setNZ = 1'b1;
                setC  = 1'b1;
            end
            NOP: ;
            default: kept = 1'b0;
        endcase

        // set commands drive ones under their own mask
        fval = {8{decoded.cmd inside {SEC, SEI, SED}}};
        if (setNZ) begin
            mask[flagN] = 1'b1;
            mask[flagZ] = 1'b1;
            fval[flagN] = value[7];
            fval[flagZ] = (value == 8'h00);
        end
        if (setC) begin
            mask[flagC] = 1'b1;
            fval[flagC] = carry;
        end
        if (setV) begin
            mask[flagV] = 1'b1;
            fval[flagV] = overflow;
        end
    end

    assign result = '{valid: decodedValid, supported: kept && modeOk, dest: dest,
                      value: value, flagMask: mask, flagValue: fval};

endmodule

//--- hdl/opcodeDecoder.sv
`timescale 1ns/1ps

module opcodeDecoder (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    instrValid,
    input  cpu6502Pkg::opcodeWord_t opcode,
    input  logic [7:0]              operand,
    output cpu6502Pkg::decodedOp_t  decoded,
    output logic                    decodedValid
);

    import cpu6502Pkg::*;

    logic [2:0] a;
    logic [2:0] b;
    logic [1:0] c;
    cmd_t       cmd;
    addrMode_t  mode;

    assign a = opcode.fields.a;
    assign b = opcode.fields.b;
    assign c = opcode.fields.c;

    always_comb begin
        // undocumented slots read as a memory NOP, so they retire unsupported
        cmd  = NOP;
        mode = abs;

        case (c)
            2'b00: begin
                case (b)
                    3'b000: begin
                        mode = immediate; // LDY, CPY, CPX row
                        case (a)
                            3'b000: begin
                                cmd  = BRK;
                                mode = impl;
                            end
                            3'b001: begin
                                cmd  = JSR;
                                mode = abs;
                            end
                            3'b010: begin
                                cmd  = RTI;
                                mode = impl;
                            end
                            3'b011: begin
                                cmd  = RTS;
                                mode = impl;
                            end
                            3'b101: cmd = LDY;
                            3'b110: cmd = CPY;
                            3'b111: cmd = CPX;
                            default: mode = abs;
                        endcase
                    end
                    3'b001: begin
                        mode = zpg;
                        case (a)
                            3'b001: cmd = BIT;
                            3'b100: cmd = STY;
                            3'b101: cmd = LDY;
                            3'b110: cmd = CPY;
                            3'b111: cmd = CPX;
                            default: cmd = NOP;
                        endcase
                    end
                    3'b010: begin
                        mode = impl;
                        case (a)
                            3'b000: cmd = PHP;
                            3'b001: cmd = PLP;
                            3'b010: cmd = PHA;
                            3'b011: cmd = PLA;
                            3'b100: cmd = DEY;
                            3'b101: cmd = TAY;
                            3'b110: cmd = INY;
                            default: cmd = INX;
                        endcase
                    end
                    3'b011: begin
                        mode = abs;
                        case (a)
                            3'b001: cmd = BIT;
                            3'b010: cmd = JMP;
                            3'b011: begin
                                cmd  = JMP;
                                mode = ind;
                            end
                            3'b100: cmd = STY;
                            3'b101: cmd = LDY;
                            3'b110: cmd = CPY;
                            3'b111: cmd = CPX;
                            default: cmd = NOP;
                        endcase
                    end
                    3'b100: begin
                        mode = rel;
                        case (a)
                            3'b000: cmd = BPL;
                            3'b001: cmd = BMI;
                            3'b010: cmd = BVC;
                            3'b011: cmd = BVS;
                            3'b100: cmd = BCC;
                            3'b101: cmd = BCS;
                            3'b110: cmd = BNE;
                            default: cmd = BEQ;
                        endcase
                    end
                    3'b101: begin
                        mode = zpgX;
                        if (a == 3'b100)
                            cmd = STY;
                        else if (a == 3'b101)
                            cmd = LDY;
                    end
                    3'b110: begin
                        mode = impl;
                        case (a)
                            3'b000: cmd = CLC;
                            3'b001: cmd = SEC;
                            3'b010: cmd = CLI;
                            3'b011: cmd = SEI;
                            3'b100: cmd = TYA;
                            3'b101: cmd = CLV;
                            3'b110: cmd = CLD;
                            default: cmd = SED;
                        endcase
                    end
                    default: begin
                        mode = absX;
                        if (a == 3'b101)
                            cmd = LDY;
                    end
                endcase
            end

            2'b01: begin
                case (b) // group one, mode from b alone
                    3'b000: mode = Xind;
                    3'b001: mode = zpg;
                    3'b010: mode = immediate;
                    3'b011: mode = abs;
                    3'b100: mode = indY;
                    3'b101: mode = zpgX;
                    3'b110: mode = absY;
                    default: mode = absX;
                endcase
                case (a)
                    3'b000: cmd = ORA;
                    3'b001: cmd = AND;
                    3'b010: cmd = EOR;
                    3'b011: cmd = ADC;
                    3'b100: cmd = STA;
                    3'b101: cmd = LDA;
                    3'b110: cmd = CMP;
                    default: cmd = SBC;
                endcase
            end

            2'b10: begin
                case (b)
                    3'b000: begin
                        if (a == 3'b101) begin
                            cmd  = LDX;
                            mode = immediate;
                        end
                    end
                    3'b010: begin
                        mode = impl;
                        case (a)
                            3'b000: cmd = ASLA;
                            3'b001: cmd = ROLA;
                            3'b010: cmd = LSRA;
                            3'b011: cmd = RORA;
                            3'b100: cmd = TXA;
                            3'b101: cmd = TAX;
                            3'b110: cmd = DEX;
                            default: cmd = NOP;
                        endcase
                        if (!a[2])
                            mode = accum; // shifts on A
                    end
                    3'b110: begin
                        mode = impl;
                        if (a == 3'b100)
                            cmd = TXS;
                        else if (a == 3'b101)
                            cmd = TSX;
                        else
                            mode = abs;
                    end
                    3'b100: cmd = NOP; // jam row, never executed
                    default: begin
                        // b = 001, 011, 101, 111: read-modify-write rows
                        case (b)
                            3'b001: mode = zpg;
                            3'b011: mode = abs;
                            3'b101: mode = (a[2:1] == 2'b10) ? zpgY : zpgX;
                            default: mode = (a[2:1] == 2'b10) ? absY : absX;
                        endcase
                        case (a)
                            3'b000: cmd = ASL;
                            3'b001: cmd = ROL;
                            3'b010: cmd = LSR;
                            3'b011: cmd = ROR;
                            3'b100: cmd = (b == 3'b111) ? NOP : STX;
                            3'b101: cmd = LDX;
                            3'b110: cmd = DEC;
                            default: cmd = INC;
                        endcase
                    end
                endcase
            end

            default: cmd = NOP; // c = 11 is all undocumented
        endcase
    end

    always_ff @(posedge clk) begin
        decoded <= '{cmd: cmd, mode: mode, operand: operand};
        if (reset)
            decodedValid <= 1'b0;
        else
            decodedValid <= instrValid;
    end

endmodule

//--- hdl/cpu6502Pkg.sv
package cpu6502Pkg;

`include "cpu6502_config.svh"

    // every mnemonic the opcode matrix can produce
    typedef enum logic [`CMD_WIDTH-1:0] {
        BRK, JSR, RTI, RTS, BIT, JMP,
        PHP, PLP, PHA, PLA,
        LDA, LDX, LDY, STA, STX, STY,
        TAX, TAY, TXA, TYA, TSX, TXS,
        INX, INY, DEX, DEY, INC, DEC,
        BPL, BMI, BVC, BVS, BCC, BCS, BNE, BEQ,
        CLC, SEC, CLI, SEI, CLV, CLD, SED,
        ORA, AND, EOR, ADC, SBC, CMP, CPX, CPY,
        ASL, ROL, LSR, ROR,
        ASLA, ROLA, LSRA, RORA,
        NOP
    } cmd_t;

    typedef enum logic [`MODE_WIDTH-1:0] {
        impl, accum, immediate,
        zpg, zpgX, zpgY,
        abs, absX, absY,
        ind, Xind, indY,
        rel
    } addrMode_t;

    // opcode byte seen either whole or as its aaabbbcc fields
    typedef union packed {
        logic [7:0] raw;
        struct packed {
            logic [2:0] a;
            logic [2:0] b;
            logic [1:0] c;
        } fields;
    } opcodeWord_t;

    typedef struct packed {
        cmd_t       cmd;
        addrMode_t  mode;
        logic [7:0] operand;
    } decodedOp_t;

    typedef enum logic [2:0] {
        none, regA, regX, regY, regS
    } destReg_t;

    typedef struct packed {
        logic       valid;
        logic       supported;
        destReg_t   dest;
        logic [7:0] value;
        logic [7:0] flagMask;  // which P bits this result touches
        logic [7:0] flagValue;
    } execResult_t;

    typedef struct packed {
        logic [7:0] a;
        logic [7:0] x;
        logic [7:0] y;
        logic [7:0] s;
        logic [7:0] p; // NV1BDIZC
    } regFile_t;

endpackage

//--- hdl/cpu6502_config.svh
`ifndef CPU6502_CONFIG_SVH
`define CPU6502_CONFIG_SVH

// widths of the decoder outputs
`define CMD_WIDTH 6
`define MODE_WIDTH 4

// architectural state after reset
`define SP_RESET 8'hFD
`define P_RESET 8'h24 // bit 5 tied high, I set

`endif
